// File: include/iq_macros.svh
// Instruction queue cluster sizing
// Depth per lane and the number of execution lanes

`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// Entries per lane queue
// Must be a power of two, 2 or more, so the pointers wrap on their own
`define IQ_NUM_ENTRIES 8

// One lane per execution class (ALU, MEM, CTRL)
// Tied to the lane_e encoding, not a free knob
`define IQ_NUM_LANES 3

`endif

// File: rtl/riscv_pkg.sv
// RV32I instruction encodings
// Major opcodes and the R / I views of a 32-bit word

package riscv_pkg;

    // Base opcodes handled by the steer unit
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // Register-register ALU
        OP_IMM = 7'b0010011,  // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,  // Conditional branches
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // R-type layout, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;  // Raw bits, may hold a non-RV32I value
    } r_fields_t;

    // I-type layout
    typedef struct packed {
        logic [11:0] imm12;   // Sign bit at [11]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // Same 32 bits seen three ways
    typedef union packed {
        logic [31:0] raw;
        r_fields_t   r;   // Register fields
        i_fields_t   i;   // Immediate field
    } instr_word_u;

endpackage

// File: rtl/iq_pkg.sv
// Issue queue micro-architecture types
// Lane encoding, queued entry and the fetch / issue bundles

package iq_pkg;

    import riscv_pkg::*;

    // Execution class, also the queue index
    typedef enum logic [1:0] {
        LANE_ALU  = 2'd0,
        LANE_MEM  = 2'd1,
        LANE_CTRL = 2'd2
    } lane_e;

    // Decoded instruction as held in a lane queue
    typedef struct packed {
        logic        valid;    // Write request into the target queue
        logic        illegal;  // Opcode outside RV32I base set
        lane_e       lane;
        logic [31:0] pc;
        instr_word_u word;     // Original encoding kept for later stages
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;      // Zero when the opcode has no I immediate
    } instr_entry_t;

    // Request from fetch
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instr_word_u word;
    } fetch_req_t;

    // Towards operand read
    typedef struct packed {
        logic         valid;
        instr_entry_t entry;
    } issue_t;

endpackage

// File: rtl/instr_steer.sv
// Decode and steer stage
// Splits a fetched word into fields and picks the execution lane

`timescale 1ns/1ps

`include "iq_macros.svh"

module instr_steer
    import riscv_pkg::*;
    import iq_pkg::*;
(
    input  fetch_req_t                 fetch_i,       // Instruction from fetch
    output instr_entry_t               entry_o,       // Decoded entry, shared by all queues
    output lane_e                      lane_o,        // Target lane of entry_o
    input  logic [`IQ_NUM_LANES-1:0]   lane_full_i,   // Per-lane full flags
    output logic                       fetch_ready_o  // Target lane has room
);

    lane_e lane;
    logic  illegal;
    logic  use_imm;  // I-type immediate is meaningful

    // Opcode classification
    always_comb begin
        lane    = LANE_ALU;
        illegal = 1'b0;
        use_imm = 1'b0;
        case (fetch_i.word.r.opcode)
            OP: begin
                lane = LANE_ALU;
            end
            OP_IMM: begin
                lane    = LANE_ALU;
                use_imm = 1'b1;
            end
            LOAD: begin
                lane    = LANE_MEM;
                use_imm = 1'b1;
            end
            STORE: begin
                lane = LANE_MEM;   // S-type imm is split, not taken here
            end
            BRANCH, JAL: begin
                lane = LANE_CTRL;
            end
            JALR: begin
                lane    = LANE_CTRL;
                use_imm = 1'b1;
            end
            default: begin
                lane    = LANE_ALU;  // Unknown opcodes park in ALU
                illegal = 1'b1;
            end
        endcase
    end

    // Back-pressure from the chosen lane only
    assign fetch_ready_o = ~lane_full_i[lane];
    assign lane_o        = lane;

    // Entry assembly
    always_comb begin
        entry_o         = '0;
        entry_o.valid   = fetch_i.valid & fetch_ready_o;  // Only when accepted
        entry_o.illegal = illegal;
        entry_o.lane    = lane;
        entry_o.pc      = fetch_i.pc;
        entry_o.word    = fetch_i.word;
        entry_o.rd      = fetch_i.word.r.rd;   // Register fields from the R view always
        entry_o.rs1     = fetch_i.word.r.rs1;
        entry_o.rs2     = fetch_i.word.r.rs2;
        entry_o.imm     = use_imm ? fetch_i.word.i.imm12 : 12'h000;
    end

endmodule

// File: rtl/instruction_queue.sv
// Per-lane instruction queue
// Circular buffer of decoded entries, head read is combinational

`timescale 1ns/1ps

`include "iq_macros.svh"

module instruction_queue
    import iq_pkg::*;
#(
    parameter int NUM_ENTRIES = `IQ_NUM_ENTRIES
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  instr_entry_t instruction_i,  // Written when valid and not full
    input  logic         flush_i,        // Drop every entry
    input  logic         read_head_i,    // Pop the oldest entry
    output instr_entry_t instruction_o,  // Head entry, zero unless popped
    output logic         full_o,
    output logic         empty_o
);

    localparam int PTR_W = $clog2(NUM_ENTRIES);
    localparam int CNT_W = PTR_W + 1;  // Must hold NUM_ENTRIES itself

    logic [PTR_W-1:0] head_q;    // Oldest entry
    logic [PTR_W-1:0] tail_q;    // Next free slot
    logic [CNT_W-1:0] count_q;
    logic             wr_en;
    logic             rd_en;

    instr_entry_t buffer_q [NUM_ENTRIES];

    assign empty_o = (count_q == '0);
    // Also full in reset and flush, which stalls fetch
    assign full_o  = (count_q == CNT_W'(NUM_ENTRIES)) | flush_i | ~rstn_i;

    assign wr_en = instruction_i.valid & ~full_o;
    assign rd_en = read_head_i & ~empty_o;

    // Storage
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            buffer_q[tail_q] <= instruction_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (wr_en) tail_q <= tail_q + PTR_W'(1);  // Wraps at the power of two
            if (rd_en) head_q <= head_q + PTR_W'(1);
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    assign instruction_o = rd_en ? buffer_q[head_q] : '0;

    // Occupancy stays within the buffer across all cycles
    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        count_q <= CNT_W'(NUM_ENTRIES)
    ) else $error("instruction_queue: count above depth");

    // The selector must never pop an empty lane
    a_no_read_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        read_head_i |-> !empty_o
    ) else $error("instruction_queue: read while empty");

endmodule

// File: rtl/issue_select.sv
// Round-robin issue selector
// Pops one non-empty lane per cycle towards the downstream stage

`timescale 1ns/1ps

`include "iq_macros.svh"

module issue_select
    import iq_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,
    input  logic [`IQ_NUM_LANES-1:0]   lane_empty_i,
    input  instr_entry_t               lane_instr_i [`IQ_NUM_LANES],  // Queue heads
    input  logic                       issue_ready_i,
    output logic [`IQ_NUM_LANES-1:0]   read_head_o,   // One-hot pop strobe
    output issue_t                     issue_o
);

    localparam int LANE_W = $clog2(`IQ_NUM_LANES);

    logic [LANE_W-1:0] ptr_q;      // Lane with highest priority
    logic [LANE_W-1:0] grant_idx;
    logic              found;      // Some lane holds work
    logic              grant;

    // First non-empty lane at or after the pointer
    always_comb begin
        int unsigned idx;
        found     = 1'b0;
        grant_idx = '0;
        for (int i = 0; i < `IQ_NUM_LANES; i++) begin
            idx = (int'(ptr_q) + i) % `IQ_NUM_LANES;
            if (!found && !lane_empty_i[idx]) begin
                found     = 1'b1;
                grant_idx = LANE_W'(idx);
            end
        end
    end

    assign grant = found & issue_ready_i & ~flush_i;  // No issue in the flush cycle

    always_comb begin
        read_head_o = '0;
        if (grant) read_head_o[grant_idx] = 1'b1;
    end

    assign issue_o.valid = grant;
    assign issue_o.entry = grant ? lane_instr_i[grant_idx] : '0;

    // Pointer moves past the granted lane
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ptr_q <= '0;
        end else if (flush_i) begin
            ptr_q <= '0;  // Back to ALU
        end else if (grant) begin
            ptr_q <= (grant_idx == LANE_W'(`IQ_NUM_LANES - 1)) ? '0 : grant_idx + LANE_W'(1);
        end
    end

    // Never pops more than one lane at a time
    a_single_pop: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $onehot0(read_head_o)
    ) else $error("issue_select: multiple read strobes");

    // Issue only into a ready stage, carrying a queued entry of the granted lane
    a_issue_ready: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        issue_o.valid |-> issue_ready_i && issue_o.entry.valid
                          && (issue_o.entry.lane == lane_e'(grant_idx))
    ) else $error("issue_select: issue without ready or from a foreign lane");

endmodule

// File: rtl/iq_cluster_top.sv
// Decode-to-issue cluster
// Steer unit, one queue per execution lane and the issue selector

`timescale 1ns/1ps

`include "iq_macros.svh"

module iq_cluster_top
    import iq_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,
    input  fetch_req_t fetch_i,
    output logic       fetch_ready_o,
    input  logic       issue_ready_i,
    output issue_t     issue_o
);

    instr_entry_t                   steer_entry;  // Shared decoded entry
    lane_e                          steer_lane;
    logic [`IQ_NUM_LANES-1:0]       lane_full;
    logic [`IQ_NUM_LANES-1:0]       lane_empty;
    logic [`IQ_NUM_LANES-1:0]       read_head;
    instr_entry_t                   lane_out [`IQ_NUM_LANES];

    instr_steer u_steer (
        .fetch_i       (fetch_i),
        .entry_o       (steer_entry),
        .lane_o        (steer_lane),
        .lane_full_i   (lane_full),
        .fetch_ready_o (fetch_ready_o)
    );

    for (genvar k = 0; k < `IQ_NUM_LANES; k++) begin : g_lane
        instr_entry_t lane_in;

        // Valid reaches the target lane only
        always_comb begin
            lane_in       = steer_entry;
            lane_in.valid = steer_entry.valid & (steer_lane == lane_e'(k));
        end

        instruction_queue #(
            .NUM_ENTRIES (`IQ_NUM_ENTRIES)
        ) u_queue (
            .clk_i         (clk_i),
            .rstn_i        (rstn_i),
            .instruction_i (lane_in),
            .flush_i       (flush_i),
            .read_head_i   (read_head[k]),
            .instruction_o (lane_out[k]),
            .full_o        (lane_full[k]),
            .empty_o       (lane_empty[k])
        );
    end

    issue_select u_select (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .lane_empty_i  (lane_empty),
        .lane_instr_i  (lane_out),
        .issue_ready_i (issue_ready_i),
        .read_head_o   (read_head),
        .issue_o       (issue_o)
    );

endmodule

// File: tb/iq_tb_pkg.sv
// Reference model of the decode-to-issue cluster
// Per-lane FIFOs, RV32I decode rules and the round-robin pointer

`include "iq_macros.svh"

package iq_tb_pkg;

    import riscv_pkg::*;
    import iq_pkg::*;

    instr_entry_t lane_q [`IQ_NUM_LANES][$];  // Accepted, not yet issued
    int unsigned  rr_ptr;                     // Lane tried first

    // Decode straight from the bit positions of the RV32I formats
    function automatic instr_entry_t decode(fetch_req_t f);
        instr_entry_t e;
        logic [31:0]  w;
        logic [6:0]   op;
        w         = f.word;
        op        = w[6:0];
        e         = '0;
        e.valid   = 1'b1;  // Queued entries are always valid
        e.pc      = f.pc;
        e.word    = f.word;
        e.rd      = w[11:7];
        e.rs1     = w[19:15];
        e.rs2     = w[24:20];
        case (op)
            OP, OP_IMM:        e.lane = LANE_ALU;
            LOAD, STORE:       e.lane = LANE_MEM;
            BRANCH, JAL, JALR: e.lane = LANE_CTRL;
            default: begin
                e.lane    = LANE_ALU;  // Unknown opcode
                e.illegal = 1'b1;
            end
        endcase
        if (op == OP_IMM || op == LOAD || op == JALR) e.imm = w[31:20];
        return e;
    endfunction

    // Reset and flush both empty every lane
    function automatic void clear_queues();
        for (int k = 0; k < `IQ_NUM_LANES; k++) lane_q[k].delete();
        rr_ptr = 0;
    endfunction

    function automatic logic lane_has_room(fetch_req_t f);
        instr_entry_t e;
        e = decode(f);
        return lane_q[e.lane].size() < `IQ_NUM_ENTRIES;
    endfunction

    // First non-empty lane from the pointer on
    function automatic issue_t predict_issue(logic ready);
        issue_t      r;
        int unsigned k;
        r = '0;
        if (ready) begin
            for (int i = 0; i < `IQ_NUM_LANES; i++) begin
                k = (rr_ptr + i) % `IQ_NUM_LANES;
                if (!r.valid && lane_q[k].size() != 0) begin
                    r.valid = 1'b1;
                    r.entry = lane_q[k][0];
                end
            end
        end
        return r;
    endfunction

    // State update for one rising edge
    function automatic void advance(logic accepted, fetch_req_t f, issue_t issued);
        instr_entry_t e;
        if (issued.valid) begin
            void'(lane_q[issued.entry.lane].pop_front());
            rr_ptr = (int'(issued.entry.lane) + 1) % `IQ_NUM_LANES;  // Past the granted lane
        end
        if (accepted) begin
            e = decode(f);
            if (lane_q[e.lane].size() < `IQ_NUM_ENTRIES) lane_q[e.lane].push_back(e);
        end
    endfunction

    function automatic logic all_empty();
        for (int k = 0; k < `IQ_NUM_LANES; k++) begin
            if (lane_q[k].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

endpackage

// File: tb/tb_iq_cluster.sv
// Testbench for the decode-to-issue cluster
// Random fetch traffic compared cycle by cycle with the reference model

`timescale 1ns/1ps

`include "iq_macros.svh"

module tb_iq_cluster
    import riscv_pkg::*;
    import iq_pkg::*;
    import iq_tb_pkg::*;
();

    localparam int DEPTH     = `IQ_NUM_ENTRIES;
    localparam int RESET_CYC = 10;
    localparam int DEC_CYC   = 300;                          // Decode sweep
    localparam int BP_CYC    = 4 * DEPTH * `IQ_NUM_LANES;    // Long enough to fill lanes
    localparam int LOAD_CYC  = DEPTH * `IQ_NUM_LANES;        // Preload for round-robin
    localparam int FLUSH_CYC = 400;
    localparam int DRAIN_CYC = 4 * DEPTH * `IQ_NUM_LANES + 4;
    localparam int NUM_DRAIN = `IQ_NUM_LANES + 4;
    localparam int LIMIT     = (RESET_CYC + 1 + DEC_CYC + LOAD_CYC + BP_CYC + LOAD_CYC
                               + FLUSH_CYC + NUM_DRAIN * DRAIN_CYC) * 11 / 10;

    logic       clk_i;
    logic       rstn_i;
    logic       flush_i;
    logic       issue_ready_i;
    logic       fetch_ready_o;
    fetch_req_t fetch_i;
    issue_t     issue_o;

    int unsigned errors;
    int unsigned checks;
    int unsigned cycle_cnt;
    logic        accepted;  // Request taken on the last edge
    logic [31:0] pc_next;
    opcode_e     ops [7] = '{OP, OP_IMM, LOAD, STORE, BRANCH, JAL, JALR};

    iq_cluster_top DUT (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .fetch_i       (fetch_i),
        .fetch_ready_o (fetch_ready_o),
        .issue_ready_i (issue_ready_i),
        .issue_o       (issue_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_issue(input issue_t got, input issue_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: issue_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: fetch_ready_o is %b, expected %b", $time, got, exp);
        end
    endtask

    // Compare at the falling edge, then move the model on the rising edge
    task automatic tick();
        issue_t exp_issue;
        logic   exp_ready;
        @(negedge clk_i);
        exp_ready = rstn_i && !flush_i && lane_has_room(fetch_i);  // Queues look full then
        exp_issue = (rstn_i && !flush_i) ? predict_issue(issue_ready_i) : '0;
        check_ready(fetch_ready_o, exp_ready);
        check_issue(issue_o, exp_issue);
        accepted = fetch_i.valid && exp_ready;
        @(posedge clk_i);
        if (!rstn_i || flush_i) clear_queues();
        else advance(accepted, fetch_i, exp_issue);
    endtask

    // Random word, optionally limited to one lane
    task automatic new_fetch(int lane_sel);
        fetch_req_t   f;
        instr_entry_t e;
        logic [6:0]   op;
        do begin
            op      = ($urandom_range(7) == 7) ? 7'($urandom()) : ops[$urandom_range(6)];
            f.valid = 1'b1;
            f.pc    = pc_next;
            f.word  = {25'($urandom()), op};
            e       = decode(f);
        end while (lane_sel >= 0 && int'(e.lane) != lane_sel);
        fetch_i <= f;
        pc_next += 32'd4;
    endtask

    // A request stays on the bus until it is accepted
    task automatic traffic(int n, int lane_sel, int ready_pct, int flush_pct);
        repeat (n) begin
            if (!fetch_i.valid || accepted) new_fetch(lane_sel);
            issue_ready_i <= ($urandom_range(99) < ready_pct);
            flush_i       <= ($urandom_range(99) < flush_pct);
            tick();
        end
    endtask

    // Lets a pending request in, then empties every lane
    task automatic drain(int ready_pct);
        while (fetch_i.valid || !all_empty()) begin
            if (accepted) fetch_i.valid <= 1'b0;
            issue_ready_i <= ($urandom_range(99) < ready_pct);
            flush_i       <= 1'b0;
            tick();
        end
    endtask

    task automatic report_test(string name, int unsigned err0);
        $display("%s: %s, %0d errors", name, (errors == err0) ? "pass" : "fail", errors - err0);
    endtask

    initial begin
        int unsigned err0;
        void'($urandom(32'hc14777a8));
        errors        = 0;
        checks        = 0;
        accepted      = 1'b0;
        pc_next       = 32'h0000_1000;
        rstn_i        = 1'b0;
        flush_i       = 1'b0;
        issue_ready_i = 1'b1;  // Only empty queues can keep issue low
        fetch_i       = '0;

        err0 = errors;
        repeat (RESET_CYC) tick();  // fetch_ready_o low while in reset
        rstn_i <= 1'b1;
        tick();
        report_test("reset state", err0);

        err0 = errors;
        traffic(DEC_CYC, -1, 100, 0);
        drain(100);
        report_test("decode and steering", err0);

        err0 = errors;
        for (int k = 0; k < `IQ_NUM_LANES; k++) begin
            traffic(DEPTH, k, 0, 0);  // One burst per lane, then drained in order
            drain(100);
        end
        report_test("lane order", err0);

        err0 = errors;
        traffic(BP_CYC, -1, 0, 0);
        drain(100);
        report_test("back-pressure", err0);

        err0 = errors;
        traffic(LOAD_CYC, -1, 0, 0);
        drain(50);
        report_test("round-robin", err0);

        err0 = errors;
        traffic(FLUSH_CYC, -1, 70, 5);
        drain(100);
        report_test("flush", err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < LIMIT) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
rtl/riscv_pkg.sv
rtl/iq_pkg.sv
rtl/instr_steer.sv
rtl/instruction_queue.sv
rtl/issue_select.sv
rtl/iq_cluster_top.sv
tb/iq_tb_pkg.sv
tb/tb_iq_cluster.sv

// File: Bender.yml
package:
  name: iq_cluster

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/riscv_pkg.sv
      - rtl/iq_pkg.sv
      - rtl/instr_steer.sv
      - rtl/instruction_queue.sv
      - rtl/issue_select.sv
      - rtl/iq_cluster_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/iq_tb_pkg.sv
      - tb/tb_iq_cluster.sv
